//--- files.f
+incdir+design
design/csr_pkg.sv
design/event_counter.sv
design/event_sampler.sv
design/hot_page_buffer.sv
design/csr_regfile.sv
design/avmm_slave_ctrl.sv
design/custom_csr_top.sv
sim/tb_custom_csr.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing
TOP       = tb_custom_csr
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_custom_csr.sv
`include "csr_defs.svh"

module tb_custom_csr;
    timeunit 1ns;
    timeprecision 1ps;

    // tick wait plus 1025 tracker stores and the bus traffic around them
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RESET_CYCLES   = 3;
    localparam int TICK_WAIT      = 10100;

    logic                    avmm_clk;
    logic                    reset_n;
    logic [`CSR_DATA_W-1:0]  writedata_i;
    logic                    read_i;
    logic                    write_i;
    logic [7:0]              byteenable_i;
    logic [`CSR_ADDR_W-1:0]  address_i;
    logic                    cxl_read_event_i;
    logic                    cxl_write_event_i;
    logic                    page_mig_addr_en_i;
    logic [`MIG_ADDR_W-1:0]  page_mig_addr_i;
    logic [`CSR_DATA_W-1:0]  readdata_o;
    logic                    readdatavalid_o;
    logic                    waitrequest_o;
    logic [31:0]             page_query_rate_o;
    logic [`CSR_DATA_W-1:0]  cxl_start_pa_o;
    logic [`CSR_DATA_W-1:0]  cxl_addr_offset_o;
    logic [`CSR_DATA_W-1:0]  write_back_addr_o;
    logic [31:0]             csr_write_back_cnt_o;
    logic                    csr_zero_out_o;
    logic                    csr_write_back_o;

    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    logic [15:0] lfsr_q = 16'd7467;
    logic [63:0] shadow [`REG_PAGE_RATE:`CSR_REG_COUNT-1];
    logic [63:0] prog_pa;
    logic [63:0] prog_off;

    custom_csr_top dut0 (.*);

    always #4 avmm_clk = ~avmm_clk;

    always @(posedge avmm_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // ==================================================================
    // helpers
    // ==================================================================
    // taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic logic [63:0] lane_mask(input logic [7:0] be);
        logic [63:0] m;
        for (int b = 0; b < 8; b++) begin
            m[b*8 +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    function automatic logic [`CSR_ADDR_W-1:0] byte_addr(input int idx);
        return `CSR_ADDR_W'(idx * 8);
    endfunction

    function automatic logic [15:0] addr_lo(input int idx);
        return 16'(idx * 8);
    endfunction

    // tracker page to byte address, add offset, wrap at 8 GB, back to pages
    function automatic logic [31:0] page_number(input logic [27:0] mig,
                                                input logic [63:0] pa,
                                                input logic [63:0] off);
        logic [63:0] addr;
        addr = {36'd0, mig} << 12;
        addr = (addr + off) % 64'h2_0000_0000;
        addr = (addr >> 12) + (pa >> 12);
        return addr[31:0];
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic bus_write(input int idx, input logic [63:0] data, input logic [7:0] be);
        int waits;
        waits = 0;
        @(posedge avmm_clk);
        address_i    <= byte_addr(idx);
        writedata_i  <= data;
        byteenable_i <= be;
        write_i      <= 1'b1;
        @(negedge avmm_clk);
        while (waitrequest_o) begin
            @(negedge avmm_clk);
            waits++;
        end
        @(posedge avmm_clk);
        write_i <= 1'b0;
        check_value("waitrequest_o cycles on write", 64'd1, 64'(waits));
    endtask

    // lat counts cycles from acceptance to readdatavalid
    task automatic bus_read(input int idx, input logic [7:0] be,
                            output logic [63:0] data, output int lat);
        lat  = 0;
        data = '0;
        @(posedge avmm_clk);
        address_i    <= byte_addr(idx);
        byteenable_i <= be;
        read_i       <= 1'b1;
        @(negedge avmm_clk);
        while (waitrequest_o) begin
            @(negedge avmm_clk);
            lat++;
        end
        check_value("waitrequest_o cycles on read", 64'd1, 64'(lat));
        @(posedge avmm_clk);
        read_i <= 1'b0;
        do begin
            @(negedge avmm_clk);
            lat++;
        end while (!readdatavalid_o && lat < 8);
        if (!readdatavalid_o) begin
            errors++;
            $display("readdatavalid_o never rose for the read of word %0d", idx);
        end
        data = readdata_o;
        @(negedge avmm_clk);
        check_value("readdatavalid_o after its cycle", 64'd0, 64'(readdatavalid_o));
    endtask

    // ==================================================================
    // directed tests
    // ==================================================================
    task automatic reset_timing_test();
        logic [63:0] rd;
        int          lat;
        check_value("page_query_rate_o", 64'd0, 64'(page_query_rate_o));
        check_value("cxl_start_pa_o", 64'd0, cxl_start_pa_o);
        check_value("cxl_addr_offset_o", 64'd0, cxl_addr_offset_o);
        check_value("write_back_addr_o", 64'd0, write_back_addr_o);
        check_value("csr_write_back_cnt_o", 64'd0, 64'(csr_write_back_cnt_o));
        check_value("csr_zero_out_o", 64'd0, 64'(csr_zero_out_o));
        check_value("csr_write_back_o", 64'd0, 64'(csr_write_back_o));
        for (int r = `REG_TICK; r <= `REG_PFN_STATUS; r++) begin
            bus_read(r, 8'hFF, rd, lat);
            check_value($sformatf("readdata_o reg %0d", r), 64'd0, rd);
            check_value("readdatavalid_o latency", 64'd2, 64'(lat));
        end
        bus_read(`PFN_WINDOW_BASE, 8'hFF, rd, lat);
        check_value("readdatavalid_o latency (buffer)", 64'd3, 64'(lat));
        check_value("readdata_o tag", 64'({`PFN_TAG, addr_lo(`PFN_WINDOW_BASE)}),
                    64'(rd[63:32]));
        // one index between registers and window, one above the window
        bus_read(200, 8'hFF, rd, lat);
        check_value("readdata_o unmapped", {`UNMAPPED_HI, addr_lo(200), `UNMAPPED_LO}, rd);
        check_value("readdatavalid_o latency", 64'd2, 64'(lat));
        bus_read(6000, 8'hFF, rd, lat);
        check_value("readdata_o unmapped", {`UNMAPPED_HI, addr_lo(6000), `UNMAPPED_LO}, rd);
    endtask

    task automatic register_test();
        logic [63:0] data;
        logic [63:0] rd;
        logic [7:0]  be;
        int          lat;
        for (int r = `REG_PAGE_RATE; r < `CSR_REG_COUNT; r++) begin
            shadow[r] = '0;
        end
        for (int r = `REG_PAGE_RATE; r < `CSR_REG_COUNT; r++) begin
            data      = rand_bits(64);
            be        = 8'(rand_bits(8));
            shadow[r] = (shadow[r] & ~lane_mask(be)) | (data & lane_mask(be));
            bus_write(r, data, be);
        end
        for (int r = `REG_PAGE_RATE; r < `CSR_REG_COUNT; r++) begin
            bus_read(r, 8'hFF, rd, lat);
            check_value($sformatf("readdata_o reg %0d", r), shadow[r], rd);
        end
        // partial lane reads
        bus_read(`REG_WB_ADDR, 8'h0F, rd, lat);
        check_value("readdata_o low lanes", shadow[`REG_WB_ADDR] & lane_mask(8'h0F), rd);
        bus_read(`REG_WB_ADDR, 8'hF0, rd, lat);
        check_value("readdata_o high lanes", shadow[`REG_WB_ADDR] & lane_mask(8'hF0), rd);
        // configuration outputs follow their registers
        check_value("page_query_rate_o", 64'(shadow[`REG_PAGE_RATE][31:0]),
                    64'(page_query_rate_o));
        check_value("cxl_start_pa_o", shadow[`REG_START_PA], cxl_start_pa_o);
        check_value("cxl_addr_offset_o", shadow[`REG_ADDR_OFFSET], cxl_addr_offset_o);
        check_value("write_back_addr_o", shadow[`REG_WB_ADDR], write_back_addr_o);
        check_value("csr_write_back_cnt_o", 64'(shadow[`REG_WB_CNT][31:0]),
                    64'(csr_write_back_cnt_o));
    endtask

    task automatic event_count_test();
        logic [63:0] rd;
        int          lat;
        int          n_rd;
        int          n_wr;
        int          n_mig;
        n_rd  = 1 + int'(rand_bits(3)) % 5;
        n_wr  = 1 + int'(rand_bits(3)) % 5;
        n_mig = 1 + int'(rand_bits(3)) % 5;
        for (int i = 0; i < 5; i++) begin
            @(posedge avmm_clk);
            cxl_read_event_i   <= (i < n_rd);
            cxl_write_event_i  <= (i < n_wr);
            page_mig_addr_en_i <= (i < n_mig);
            // all-ones address counts the event but stores nothing
            page_mig_addr_i    <= '1;
        end
        @(posedge avmm_clk);
        cxl_read_event_i   <= 1'b0;
        cxl_write_event_i  <= 1'b0;
        page_mig_addr_en_i <= 1'b0;
        bus_read(`REG_MEM_RD, 8'hFF, rd, lat);
        check_value("readdata_o read count", 64'(n_rd), rd);
        bus_read(`REG_MEM_WR, 8'hFF, rd, lat);
        check_value("readdata_o write count", 64'(n_wr), rd);
        bus_read(`REG_PAGE_MIG, 8'hFF, rd, lat);
        check_value("readdata_o migration count", 64'(n_mig), rd);
    endtask

    task automatic page_store_test();
        logic [27:0] addrs [6];
        logic [31:0] pfns [$];
        logic [63:0] rd;
        int          lat;
        prog_pa  = rand_bits(64);
        prog_off = rand_bits(64);
        bus_write(`REG_START_PA, prog_pa, 8'hFF);
        bus_write(`REG_ADDR_OFFSET, prog_off, 8'hFF);
        check_value("cxl_start_pa_o", prog_pa, cxl_start_pa_o);
        check_value("cxl_addr_offset_o", prog_off, cxl_addr_offset_o);
        for (int k = 0; k < 6; k++) begin
            addrs[k] = 28'(rand_bits(28));
            if (addrs[k] == '1) begin
                addrs[k][0] = 1'b0;
            end
        end
        addrs[3] = '1;
        for (int k = 0; k < 6; k++) begin
            @(posedge avmm_clk);
            page_mig_addr_en_i <= 1'b1;
            page_mig_addr_i    <= addrs[k];
            if (addrs[k] != '1) begin
                pfns.push_back(page_number(addrs[k], prog_pa, prog_off));
            end
        end
        @(posedge avmm_clk);
        page_mig_addr_en_i <= 1'b0;
        for (int k = 0; k < pfns.size(); k++) begin
            bus_read(`PFN_WINDOW_BASE + k, 8'hFF, rd, lat);
            check_value($sformatf("readdata_o buffer entry %0d", k),
                        {`PFN_TAG, addr_lo(`PFN_WINDOW_BASE + k), pfns[k]}, rd);
        end
        bus_read(`REG_PFN_STATUS, 8'hFF, rd, lat);
        check_value("readdata_o write index", 64'(pfns.size()), rd);
    endtask

    task automatic overflow_test();
        logic [63:0] rd;
        int          lat;
        bus_write(`REG_PFN_IDX_RST, 64'h1, 8'hFF);
        bus_read(`REG_PFN_STATUS, 8'hFF, rd, lat);
        check_value("readdata_o write index after reset", 64'd0, rd);
        for (int k = 0; k <= 1024; k++) begin
            @(posedge avmm_clk);
            page_mig_addr_en_i <= 1'b1;
            page_mig_addr_i    <= 28'(k);
        end
        @(posedge avmm_clk);
        page_mig_addr_en_i <= 1'b0;
        bus_read(`REG_PFN_STATUS, 8'hFF, rd, lat);
        check_value("readdata_o overflow status", {32'd1, 32'd1}, rd);
        // entry 0 now holds the 1025th store
        bus_read(`PFN_WINDOW_BASE, 8'hFF, rd, lat);
        check_value("readdata_o wrapped entry",
                    {`PFN_TAG, addr_lo(`PFN_WINDOW_BASE),
                     page_number(28'd1024, prog_pa, prog_off)}, rd);
    endtask

    task automatic pulse_test(input int idx, input logic [63:0] data);
        string name;
        logic  pulse;
        logic  expected;
        name = (idx == `REG_ZERO_OUT) ? "csr_zero_out_o" : "csr_write_back_o";
        @(posedge avmm_clk);
        address_i    <= byte_addr(idx);
        writedata_i  <= data;
        byteenable_i <= 8'hFF;
        write_i      <= 1'b1;
        // c counts cycles from acceptance
        for (int c = 0; c < 7; c++) begin
            @(negedge avmm_clk);
            pulse    = (idx == `REG_ZERO_OUT) ? csr_zero_out_o : csr_write_back_o;
            expected = (data != '0) && (c >= 1) && (c <= 4);
            check_value($sformatf("%s at T+%0d", name, c), 64'(expected), 64'(pulse));
            if (c == 1) begin
                check_value("waitrequest_o at T+1", 64'd0, 64'(waitrequest_o));
                @(posedge avmm_clk);
                write_i <= 1'b0;
            end
        end
    endtask

    task automatic tick_test();
        logic [63:0] rd;
        int          lat;
        while (cycle_cnt < RESET_CYCLES + TICK_WAIT) begin
            @(posedge avmm_clk);
        end
        bus_read(`REG_TICK, 8'hFF, rd, lat);
        check_value("readdata_o tick count", 64'd1, rd);
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        avmm_clk           = 1'b0;
        reset_n            = 1'b0;
        writedata_i        = '0;
        read_i             = 1'b0;
        write_i            = 1'b0;
        byteenable_i       = '0;
        address_i          = '0;
        cxl_read_event_i   = 1'b0;
        cxl_write_event_i  = 1'b0;
        page_mig_addr_en_i = 1'b0;
        page_mig_addr_i    = '0;
        repeat (RESET_CYCLES) @(posedge avmm_clk);
        reset_n <= 1'b1;

        reset_timing_test();
        register_test();
        event_count_test();
        page_store_test();
        overflow_test();
        pulse_test(`REG_ZERO_OUT, 64'h5);
        pulse_test(`REG_WRITE_BACK, 64'h100);
        pulse_test(`REG_ZERO_OUT, 64'h0);
        pulse_test(`REG_WRITE_BACK, 64'h0);
        tick_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- design/custom_csr_top.sv
`include "csr_defs.svh"

module custom_csr_top (
    input  logic                       avmm_clk,
    input  logic                       reset_n,
    input  csr_pkg::csr_word_t         writedata_i,
    input  logic                       read_i,
    input  logic                       write_i,
    input  logic [`CSR_DATA_W/8-1:0]   byteenable_i,
    input  logic [`CSR_ADDR_W-1:0]     address_i,
    input  logic                       cxl_read_event_i,
    input  logic                       cxl_write_event_i,
    input  logic                       page_mig_addr_en_i,
    input  csr_pkg::mig_addr_t         page_mig_addr_i,
    output csr_pkg::csr_word_t         readdata_o,
    output logic                       readdatavalid_o,
    output logic                       waitrequest_o,
    output logic [31:0]                page_query_rate_o,
    output csr_pkg::csr_word_t         cxl_start_pa_o,
    output csr_pkg::csr_word_t         cxl_addr_offset_o,
    output csr_pkg::csr_word_t         write_back_addr_o,
    output logic [31:0]                csr_write_back_cnt_o,
    output logic                       csr_zero_out_o,
    output logic                       csr_write_back_o
);
    import csr_pkg::*;

    host_req_t  host_req;
    host_cfg_t  cfg;
    event_vec_t events;
    csr_word_t  counts [`CSR_NUM_EVENTS];
    pfn_t       pfn_rd;
    buf_idx_t   pfn_wr_idx;
    logic       buf_rd;
    logic       rd_done;
    logic       pfn_idx_rst;
    logic       pfn_overflow;

    assign page_query_rate_o    = cfg.page_query_rate;
    assign cxl_start_pa_o       = cfg.cxl_start_pa;
    assign cxl_addr_offset_o    = cfg.cxl_addr_offset;
    assign write_back_addr_o    = cfg.write_back_addr;
    assign csr_write_back_cnt_o = cfg.write_back_cnt;

    avmm_slave_ctrl u_slave (
        .avmm_clk        (avmm_clk),
        .reset_n         (reset_n),
        .read_i          (read_i),
        .write_i         (write_i),
        .address_i       (address_i),
        .writedata_i     (writedata_i),
        .byteenable_i    (byteenable_i),
        .req_o           (host_req),
        .buf_rd_o        (buf_rd),
        .rd_done_o       (rd_done),
        .waitrequest_o   (waitrequest_o),
        .readdatavalid_o (readdatavalid_o)
    );

    csr_regfile u_regfile (
        .avmm_clk       (avmm_clk),
        .reset_n        (reset_n),
        .req_i          (host_req),
        .rd_done_i      (rd_done),
        .counts_i       (counts),
        .pfn_rd_i       (pfn_rd),
        .pfn_wr_idx_i   (pfn_wr_idx),
        .pfn_overflow_i (pfn_overflow),
        .cfg_o          (cfg),
        .pfn_idx_rst_o  (pfn_idx_rst),
        .readdata_o     (readdata_o),
        .zero_out_o     (csr_zero_out_o),
        .write_back_o   (csr_write_back_o)
    );

    event_sampler u_sampler (
        .avmm_clk           (avmm_clk),
        .reset_n            (reset_n),
        .cxl_read_event_i   (cxl_read_event_i),
        .cxl_write_event_i  (cxl_write_event_i),
        .page_mig_addr_en_i (page_mig_addr_en_i),
        .events_o           (events)
    );

    // tick, memory read, memory write and page migration counts
    for (genvar i = 0; i < `CSR_NUM_EVENTS; i++) begin : g_counter
        event_counter u_counter (
            .avmm_clk (avmm_clk),
            .reset_n  (reset_n),
            .inc_i    (events[i]),
            .count_o  (counts[i])
        );
    end

    // the window base is 1024-aligned, so the low index bits address the buffer
    hot_page_buffer u_buffer (
        .avmm_clk           (avmm_clk),
        .reset_n            (reset_n),
        .cfg_i              (cfg),
        .page_mig_addr_en_i (page_mig_addr_en_i),
        .page_mig_addr_i    (page_mig_addr_i),
        .idx_rst_i          (pfn_idx_rst),
        .rd_en_i            (buf_rd),
        .rd_idx_i           (host_req.index[`PFN_DEPTH_LOG2-1:0]),
        .rd_pfn_o           (pfn_rd),
        .wr_idx_o           (pfn_wr_idx),
        .overflow_o         (pfn_overflow)
    );

endmodule

//--- design/avmm_slave_ctrl.sv
`include "csr_defs.svh"

module avmm_slave_ctrl (
    input  logic                       avmm_clk,
    input  logic                       reset_n,
    input  logic                       read_i,
    input  logic                       write_i,
    input  logic [`CSR_ADDR_W-1:0]     address_i,
    input  csr_pkg::csr_word_t         writedata_i,
    input  logic [`CSR_DATA_W/8-1:0]   byteenable_i,
    output csr_pkg::host_req_t         req_o,
    output logic                       buf_rd_o,
    output logic                       rd_done_o,
    output logic                       waitrequest_o,
    output logic                       readdatavalid_o
);
    import csr_pkg::*;

    avmm_state_e state;
    avmm_state_e next_state;
    host_req_t   bus_req;
    host_req_t   held_req;
    word_idx_t   bus_idx;
    logic        accept;

    assign bus_idx = address_i[`CSR_ADDR_W-1:3];
    assign accept  = (state == ST_IDLE) && (write_i || read_i);

    // live view of the bus, with the only region decode in the design
    always_comb begin
        bus_req            = '0;
        bus_req.index      = bus_idx;
        bus_req.addr_lo    = address_i[15:0];
        bus_req.writedata  = writedata_i;
        bus_req.byteenable = byteenable_i;
        if (bus_idx < word_idx_t'(`CSR_REG_COUNT)) begin
            bus_req.region = REGION_REG;
        end else if (bus_idx >= word_idx_t'(`PFN_WINDOW_BASE) &&
                     bus_idx <  word_idx_t'(`PFN_WINDOW_END)) begin
            bus_req.region = REGION_BUF;
        end else begin
            bus_req.region = REGION_NONE;
        end
    end

    // the accepting cycle sees the bus directly, later cycles the capture
    always_comb begin
        req_o       = accept ? bus_req : held_req;
        req_o.write = accept && write_i;
        req_o.read  = accept && !write_i;
    end

    always_ff @(posedge avmm_clk) begin
        if (accept) begin
            held_req <= bus_req;
        end
    end

    // ======================================================================
    // protocol FSM
    // ======================================================================
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (write_i) begin
                    next_state = ST_WRITE;
                end else if (read_i) begin
                    next_state = ST_READ_WAIT;
                end
            end
            ST_WRITE:     next_state = ST_IDLE;
            ST_READ_WAIT: next_state = (held_req.region == REGION_BUF) ? ST_READ_BUF
                                                                       : ST_READ_DONE;
            ST_READ_BUF:  next_state = ST_READ_DONE;
            ST_READ_DONE: next_state = ST_IDLE;
            default:      next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge avmm_clk) begin
        if (!reset_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // buffer memory is read one cycle ahead of the data register load
    assign buf_rd_o  = (state == ST_READ_WAIT) && (held_req.region == REGION_BUF);
    assign rd_done_o = ((state == ST_READ_WAIT) && (held_req.region != REGION_BUF)) ||
                       (state == ST_READ_BUF);

    assign waitrequest_o   = !((state == ST_WRITE) || (state == ST_READ_WAIT));
    assign readdatavalid_o = (state == ST_READ_DONE);

endmodule

//--- design/csr_regfile.sv
`include "csr_defs.svh"

module csr_regfile (
    input  logic                 avmm_clk,
    input  logic                 reset_n,
    input  csr_pkg::host_req_t   req_i,
    input  logic                 rd_done_i,
    input  csr_pkg::csr_word_t   counts_i [`CSR_NUM_EVENTS],
    input  csr_pkg::pfn_t        pfn_rd_i,
    input  csr_pkg::buf_idx_t    pfn_wr_idx_i,
    input  logic                 pfn_overflow_i,
    output csr_pkg::host_cfg_t   cfg_o,
    output logic                 pfn_idx_rst_o,
    output csr_pkg::csr_word_t   readdata_o,
    output logic                 zero_out_o,
    output logic                 write_back_o
);
    import csr_pkg::*;

    // host registers start at the page rate register
    localparam int HOST_FIRST = `REG_PAGE_RATE;
    localparam int REG_IDX_W  = $clog2(`CSR_REG_COUNT);
    localparam int STRETCH_W  = $clog2(`STRETCH_CYCLES + 1);

    csr_word_t            regs [HOST_FIRST:`CSR_REG_COUNT-1];
    csr_word_t            lane_mask;
    csr_word_t            wr_masked;
    csr_word_t            reg_val;
    logic                 wr_nonzero;
    logic [31:0]          ovf_cnt;
    logic [STRETCH_W-1:0] stretch_cnt;

    always_comb begin
        for (int b = 0; b < `CSR_DATA_W / 8; b++) begin
            lane_mask[b*8 +: 8] = {8{req_i.byteenable[b]}};
        end
    end

    assign wr_masked     = req_i.writedata & lane_mask;
    assign wr_nonzero    = req_i.write && (wr_masked != '0);
    assign pfn_idx_rst_o = wr_nonzero && (req_i.index == word_idx_t'(`REG_PFN_IDX_RST));

    // ======================================================================
    // host registers
    // ======================================================================
    always_ff @(posedge avmm_clk) begin
        if (!reset_n) begin
            for (int i = HOST_FIRST; i < `CSR_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (req_i.write) begin
            for (int i = HOST_FIRST; i < `CSR_REG_COUNT; i++) begin
                if (req_i.index == word_idx_t'(i)) begin
                    regs[i] <= (regs[i] & ~lane_mask) | wr_masked;
                end
            end
        end
    end

    always_ff @(posedge avmm_clk) begin
        if (!reset_n) begin
            ovf_cnt <= '0;
        end else if (pfn_overflow_i) begin
            ovf_cnt <= ovf_cnt + 1'b1;
        end
    end

    assign cfg_o.page_query_rate = regs[`REG_PAGE_RATE][31:0];
    assign cfg_o.cxl_start_pa    = regs[`REG_START_PA];
    assign cfg_o.cxl_addr_offset = regs[`REG_ADDR_OFFSET];
    assign cfg_o.write_back_addr = regs[`REG_WB_ADDR];
    assign cfg_o.write_back_cnt  = regs[`REG_WB_CNT][31:0];

    // ======================================================================
    // read path
    // ======================================================================
    always_comb begin
        reg_val = '0;
        case (req_i.index)
            word_idx_t'(`REG_TICK):       reg_val = counts_i[0];
            word_idx_t'(`REG_MEM_RD):     reg_val = counts_i[1];
            word_idx_t'(`REG_MEM_WR):     reg_val = counts_i[2];
            word_idx_t'(`REG_PAGE_MIG):   reg_val = counts_i[3];
            word_idx_t'(`REG_PFN_STATUS): reg_val = {ovf_cnt,
                                                     {(32 - `PFN_DEPTH_LOG2){1'b0}},
                                                     pfn_wr_idx_i};
            default: begin
                if (req_i.index >= word_idx_t'(HOST_FIRST) &&
                    req_i.index <  word_idx_t'(`CSR_REG_COUNT)) begin
                    reg_val = regs[req_i.index[REG_IDX_W-1:0]];
                end
            end
        endcase
    end

    always_ff @(posedge avmm_clk) begin
        if (rd_done_i) begin
            case (req_i.region)
                REGION_REG: readdata_o <= reg_val & lane_mask;
                REGION_BUF: readdata_o <= {`PFN_TAG, req_i.addr_lo, pfn_rd_i};
                default:    readdata_o <= {`UNMAPPED_HI, req_i.addr_lo, `UNMAPPED_LO};
            endcase
        end
    end

    // ======================================================================
    // control pulses
    // ======================================================================
    // both pulses share one stretch counter, a new trigger restarts it
    always_ff @(posedge avmm_clk) begin
        if (!reset_n) begin
            zero_out_o   <= 1'b0;
            write_back_o <= 1'b0;
            stretch_cnt  <= '0;
        end else begin
            if (stretch_cnt != '0) begin
                stretch_cnt <= stretch_cnt - 1'b1;
            end else begin
                zero_out_o   <= 1'b0;
                write_back_o <= 1'b0;
            end
            if (wr_nonzero && req_i.index == word_idx_t'(`REG_ZERO_OUT)) begin
                zero_out_o  <= 1'b1;
                stretch_cnt <= STRETCH_W'(`STRETCH_CYCLES);
            end
            if (wr_nonzero && req_i.index == word_idx_t'(`REG_WRITE_BACK)) begin
                write_back_o <= 1'b1;
                stretch_cnt  <= STRETCH_W'(`STRETCH_CYCLES);
            end
        end
    end

endmodule

//--- design/hot_page_buffer.sv
`include "csr_defs.svh"

module hot_page_buffer (
    input  logic                 avmm_clk,
    input  logic                 reset_n,
    input  csr_pkg::host_cfg_t   cfg_i,
    input  logic                 page_mig_addr_en_i,
    input  csr_pkg::mig_addr_t   page_mig_addr_i,
    input  logic                 idx_rst_i,
    input  logic                 rd_en_i,
    input  csr_pkg::buf_idx_t    rd_idx_i,
    output csr_pkg::pfn_t        rd_pfn_o,
    output csr_pkg::buf_idx_t    wr_idx_o,
    output logic                 overflow_o
);
    import csr_pkg::*;

    localparam int DEPTH = 1 << `PFN_DEPTH_LOG2;

    pfn_t        mem [DEPTH];
    logic        wr_en;
    logic [32:0] byte_off;
    pfn_t        wr_pfn;

    // an all-ones tracker address means no valid page
    assign wr_en = page_mig_addr_en_i && (page_mig_addr_i != '1);

    // ======================================================================
    // page number conversion
    // ======================================================================
    // byte address plus offset, wrapped at 8 GB
    assign byte_off = 33'({page_mig_addr_i, 12'h000}) + cfg_i.cxl_addr_offset[32:0];
    assign wr_pfn   = pfn_t'(52'(byte_off[32:12]) + cfg_i.cxl_start_pa[63:12]);

    // ======================================================================
    // circular store
    // ======================================================================
    always_ff @(posedge avmm_clk) begin
        if (wr_en) begin
            mem[wr_idx_o] <= wr_pfn;
        end
        if (rd_en_i) begin
            rd_pfn_o <= mem[rd_idx_i];
        end
    end

    // index reset from the host wins over a store
    always_ff @(posedge avmm_clk) begin
        if (!reset_n) begin
            wr_idx_o   <= '0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= 1'b0;
            if (idx_rst_i) begin
                wr_idx_o <= '0;
            end else if (wr_en) begin
                wr_idx_o   <= wr_idx_o + 1'b1;
                overflow_o <= (wr_idx_o == '1);
            end
        end
    end

endmodule

//--- design/event_sampler.sv
`include "csr_defs.svh"

module event_sampler (
    input  logic                 avmm_clk,
    input  logic                 reset_n,
    input  logic                 cxl_read_event_i,
    input  logic                 cxl_write_event_i,
    input  logic                 page_mig_addr_en_i,
    output csr_pkg::event_vec_t  events_o
);
    import csr_pkg::*;

    localparam int DIV_W = $clog2(`CSR_TICK_DIVISOR);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    // one tick every CSR_TICK_DIVISOR cycles
    assign tick = (div_cnt == DIV_W'(`CSR_TICK_DIVISOR - 1));

    always_ff @(posedge avmm_clk) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // strobes land one cycle late, in counter order
    always_ff @(posedge avmm_clk) begin
        if (!reset_n) begin
            events_o <= '0;
        end else begin
            events_o <= event_vec_t'({page_mig_addr_en_i, cxl_write_event_i,
                                      cxl_read_event_i, tick});
        end
    end

endmodule

//--- design/event_counter.sv
`include "csr_defs.svh"

module event_counter (
    input  logic                   avmm_clk,
    input  logic                   reset_n,
    input  logic                   inc_i,
    output logic [`CSR_DATA_W-1:0] count_o
);

    always_ff @(posedge avmm_clk) begin
        if (!reset_n) begin
            count_o <= '0;
        end else if (inc_i) begin
            count_o <= count_o + 1'b1;
        end
    end

endmodule

//--- design/csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

    typedef logic [`CSR_DATA_W-1:0]     csr_word_t;
    // byte address bits 21 to 3
    typedef logic [`CSR_ADDR_W-4:0]     word_idx_t;
    typedef logic [31:0]                pfn_t;
    typedef logic [`MIG_ADDR_W-1:0]     mig_addr_t;
    typedef logic [`PFN_DEPTH_LOG2-1:0] buf_idx_t;
    // bit 0 tick, 1 memory read, 2 memory write, 3 page migration
    typedef logic [`CSR_NUM_EVENTS-1:0] event_vec_t;

    typedef enum logic [1:0] {
        REGION_REG,
        REGION_BUF,
        REGION_NONE
    } rd_region_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ_WAIT,
        ST_READ_BUF,
        ST_READ_DONE
    } avmm_state_e;

    typedef struct packed {
        logic                      write;
        logic                      read;
        word_idx_t                 index;
        logic [15:0]               addr_lo;
        rd_region_e                region;
        csr_word_t                 writedata;
        logic [`CSR_DATA_W/8-1:0]  byteenable;
    } host_req_t;

    typedef struct packed {
        logic [31:0] page_query_rate;
        csr_word_t   cxl_start_pa;
        csr_word_t   cxl_addr_offset;
        csr_word_t   write_back_addr;
        logic [31:0] write_back_cnt;
    } host_cfg_t;

endpackage

//--- design/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// bus widths
`define CSR_DATA_W        64
`define CSR_ADDR_W        22
`define CSR_REG_COUNT     32
`define CSR_NUM_EVENTS    4
`define CSR_TICK_DIVISOR  10000

// hot-page buffer window, in word indexes
`define PFN_WINDOW_BASE   4096
`define PFN_WINDOW_END    5120
`define PFN_DEPTH_LOG2    10
`define MIG_ADDR_W        28

// register map
`define REG_TICK          0
`define REG_MEM_RD        1
`define REG_MEM_WR        2
`define REG_PAGE_MIG      3
`define REG_PFN_STATUS    4
`define REG_PAGE_RATE     8
`define REG_START_PA      10
`define REG_PFN_IDX_RST   11
`define REG_ADDR_OFFSET   14
`define REG_ZERO_OUT      16
`define REG_WRITE_BACK    17
`define REG_WB_ADDR       18
`define REG_WB_CNT        19

// extra cycles a control pulse stays high after its first one
`define STRETCH_CYCLES    3

// fill patterns returned on reads
`define UNMAPPED_HI       32'hFEDCBA00
`define UNMAPPED_LO       16'hABCD
`define PFN_TAG           16'h7469

`endif
